//--- flist.f
rtl/board_cfg_pkg.sv
rtl/board_timing_pkg.sv
rtl/clock_enable_gen.sv
rtl/reset_sequencer.sv
rtl/splash_timer.sv
rtl/settings_decoder.sv
rtl/audio_mixer.sv
rtl/sigma_delta_dac.sv
rtl/board_top.sv
sim/tb_board_top.sv

//--- rtl/audio_mixer.sv
module audio_mixer (
	input  logic                           clk_chipset,
	input  logic                           sys_reset,
	input  logic                           speaker,
	input  board_timing_pkg::fm_sample_t    fm_sample,
	input  board_timing_pkg::tandy_sample_t tandy_sample,
	output board_timing_pkg::dac_sample_t   dac_sample
);

	localparam int MIX_W = $bits(board_timing_pkg::dac_sample_t) + 1;

	logic [MIX_W-1:0] fm_term;
	logic [MIX_W-1:0] spk_term;
	logic [MIX_W-1:0] tandy_term;
	logic [MIX_W-1:0] mix_sum;

	// fm doubled
	assign fm_term    = {fm_sample, 1'b0};
	// pc speaker at a fixed level
	assign spk_term   = {2'b00, speaker, 14'd0};
	// psg into the upper byte
	assign tandy_term = {1'b0, tandy_sample, 8'd0};

	// wraps in 17 bits on full scale inputs
	assign mix_sum = fm_term + spk_term + tandy_term;

	always_ff @(posedge clk_chipset or posedge sys_reset) begin
		if (sys_reset) begin
			dac_sample <= '0;
		end else begin
			// halve the sum for the dac
			dac_sample <= mix_sum[MIX_W-1:1];
		end
	end

endmodule

//--- rtl/board_cfg_pkg.sv
package board_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// settings word layout
	////////////////////////////////////////////////////////////////////////////

	// osd reset request
	localparam int STATUS_RESET_BIT = 0;
	// 0 pcxt, 1 tandy 1000
	localparam int MODEL_BIT        = 3;
	// video output select
	localparam int MDA_BIT          = 4;
	localparam int SPLASH_SKIP_BIT  = 7;
	// ems card, active low enable
	localparam int EMS_DISABLE_BIT  = 11;
	localparam int EMS_FRAME_LSB    = 12;
	localparam int SPEED_LSB        = 17;
	// joystick types, disables and turbo sync
	localparam int JOY_OPTS_LSB     = 23;
	localparam int JOY_SWAP_BIT     = 28;

	// motherboard dip switches, mda or cga 80 columns
	localparam logic [7:0] DIP_MDA = 8'h3D;
	localparam logic [7:0] DIP_CGA = 8'h2D;

	// cpu clock choice
	typedef enum logic [1:0] {
		speed_4_77   = 2'd0,
		speed_7_16   = 2'd1,
		speed_14_318 = 2'd2
	} cpu_speed_t;

endpackage

//--- rtl/board_timing_pkg.sv
package board_timing_pkg;

	////////////////////////////////////////////////////////////////////////////
	// shared payload types
	////////////////////////////////////////////////////////////////////////////

	// settings word from the osd
	typedef logic [31:0] status_t;

	// digital joystick word
	typedef logic [31:0] joy_t;

	// unsigned fm synth sample
	typedef logic [15:0] fm_sample_t;

	// tandy psg output
	typedef logic [7:0] tandy_sample_t;

	// mixed sample into the dac
	typedef logic [15:0] dac_sample_t;

	// reset hold and cpu delay counters
	localparam int RESET_CNT_W = 16;

endpackage

//--- rtl/board_top.sv
module board_top #(
	parameter int SYNC_STAGES      = 3,
	parameter int RESET_HOLD       = 65535,
	parameter int CPU_RESET_DELAY  = 42,
	parameter int TICKS_PER_SECOND = 14318000,
	parameter int SPLASH_SECONDS   = 5
) (
	input  logic                            clk_chipset,
	input  logic                            reset_wire,
	input  board_timing_pkg::status_t       status,
	input  logic                            reset_button,
	input  logic                            download_active,
	input  logic [7:0]                      download_index,
	input  logic                            port_b_bit3,
	input  logic                            biu_done,
	input  board_timing_pkg::joy_t          joy0_in,
	input  board_timing_pkg::joy_t          joy1_in,
	input  logic                            tap_cpu_4_77,
	input  logic                            tap_cpu_7_16,
	input  logic                            tap_cpu_14_318,
	input  logic                            tap_periph,
	input  logic                            tap_opl2,
	input  logic                            tap_uart,
	input  logic                            speaker,
	input  board_timing_pkg::fm_sample_t    fm_sample,
	input  board_timing_pkg::tandy_sample_t tandy_sample,
	output logic                            sys_reset,
	output logic                            cpu_reset,
	output logic                            tandy_mode,
	output logic                            splash_active,
	output logic                            pixel_en,
	output logic                            cpu_en,
	output logic                            periph_en,
	output logic                            opl2_en,
	output logic                            uart_en,
	output board_cfg_pkg::cpu_speed_t       cpu_speed,
	output logic                            turbo_mode,
	output logic [3:0]                      port_c_nibble,
	output logic                            mda_mode,
	output logic                            ems_enabled,
	output logic [1:0]                      ems_frame,
	output logic [4:0]                      joy_opts,
	output board_timing_pkg::joy_t          joy0_out,
	output board_timing_pkg::joy_t          joy1_out,
	output board_timing_pkg::dac_sample_t   dac_sample,
	output logic                            audio_l,
	output logic                            audio_r
);

	////////////////////////////////////////////////////////////////////////////
	// settings and clocking
	////////////////////////////////////////////////////////////////////////////

	settings_decoder u_settings_decoder (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.status        (status),
		.biu_done      (biu_done),
		.port_b_bit3   (port_b_bit3),
		.joy0_in       (joy0_in),
		.joy1_in       (joy1_in),
		.cpu_speed     (cpu_speed),
		.turbo_mode    (turbo_mode),
		.port_c_nibble (port_c_nibble),
		.mda_mode      (mda_mode),
		.ems_enabled   (ems_enabled),
		.ems_frame     (ems_frame),
		.joy_opts      (joy_opts),
		.joy0_out      (joy0_out),
		.joy1_out      (joy1_out)
	);

	// enables for cpu, ppi timer, opl2 and uart
	clock_enable_gen #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_clock_enable_gen (
		.clk_chipset    (clk_chipset),
		.reset_wire     (reset_wire),
		.tap_cpu_4_77   (tap_cpu_4_77),
		.tap_cpu_7_16   (tap_cpu_7_16),
		.tap_cpu_14_318 (tap_cpu_14_318),
		.tap_periph     (tap_periph),
		.tap_opl2       (tap_opl2),
		.tap_uart       (tap_uart),
		.cpu_speed      (cpu_speed),
		.pixel_en       (pixel_en),
		.cpu_en         (cpu_en),
		.periph_en      (periph_en),
		.opl2_en        (opl2_en),
		.uart_en        (uart_en)
	);

	////////////////////////////////////////////////////////////////////////////
	// splash and reset
	////////////////////////////////////////////////////////////////////////////

	splash_timer #(
		.TICKS_PER_SECOND (TICKS_PER_SECOND),
		.SPLASH_SECONDS   (SPLASH_SECONDS)
	) u_splash_timer (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.pixel_en      (pixel_en),
		.skip          (status[board_cfg_pkg::SPLASH_SKIP_BIT]),
		.splash_active (splash_active)
	);

	// splash holds the machine in reset
	reset_sequencer #(
		.RESET_HOLD      (RESET_HOLD),
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) u_reset_sequencer (
		.clk_chipset     (clk_chipset),
		.reset_wire      (reset_wire),
		.reset_button    (reset_button),
		.status          (status),
		.splash_active   (splash_active),
		.download_active (download_active),
		.download_index  (download_index),
		.sys_reset       (sys_reset),
		.cpu_reset       (cpu_reset),
		.tandy_mode      (tandy_mode)
	);

	////////////////////////////////////////////////////////////////////////////
	// audio
	////////////////////////////////////////////////////////////////////////////

	audio_mixer u_audio_mixer (
		.clk_chipset  (clk_chipset),
		.sys_reset    (sys_reset),
		.speaker      (speaker),
		.fm_sample    (fm_sample),
		.tandy_sample (tandy_sample),
		.dac_sample   (dac_sample)
	);

	// mono mix on both channels
	sigma_delta_dac u_sigma_delta_dac (
		.clk_chipset  (clk_chipset),
		.sys_reset    (sys_reset),
		.left_sample  (dac_sample),
		.right_sample (dac_sample),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

endmodule

//--- rtl/clock_enable_gen.sv
module clock_enable_gen #(
	parameter int SYNC_STAGES = 3
) (
	input  logic                    clk_chipset,
	input  logic                    reset_wire,
	input  logic                    tap_cpu_4_77,
	input  logic                    tap_cpu_7_16,
	input  logic                    tap_cpu_14_318,
	input  logic                    tap_periph,
	input  logic                    tap_opl2,
	input  logic                    tap_uart,
	input  board_cfg_pkg::cpu_speed_t cpu_speed,
	output logic                    pixel_en,
	output logic                    cpu_en,
	output logic                    periph_en,
	output logic                    opl2_en,
	output logic                    uart_en
);

	// tap slots in the sync array
	localparam int NUM_TAPS   = 6;
	localparam int TAP_4_77   = 0;
	localparam int TAP_7_16   = 1;
	localparam int TAP_14_318 = 2;
	localparam int TAP_PERIPH = 3;
	localparam int TAP_OPL2   = 4;
	localparam int TAP_UART   = 5;

	logic [NUM_TAPS-1:0] taps;
	// sync stages plus one for the previous value
	logic [SYNC_STAGES:0] sync_chain [NUM_TAPS];
	logic [NUM_TAPS-1:0] tap_en;

	assign taps = {tap_uart, tap_opl2, tap_periph, tap_cpu_14_318, tap_cpu_7_16, tap_cpu_4_77};

	// shift each tap in, flag rising edge at the chain end
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				sync_chain[i] <= '0;
			end
			tap_en <= '0;
		end else begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				sync_chain[i] <= {sync_chain[i][SYNC_STAGES-1:0], taps[i]};
				tap_en[i]     <= sync_chain[i][SYNC_STAGES-1] & ~sync_chain[i][SYNC_STAGES];
			end
		end
	end

	// pixel clock rides on the 14.318 tap
	assign pixel_en  = tap_en[TAP_14_318];
	assign periph_en = tap_en[TAP_PERIPH];
	assign opl2_en   = tap_en[TAP_OPL2];
	assign uart_en   = tap_en[TAP_UART];

	// cpu enable, unknown codes fall back to 4.77
	always_comb begin
		case (cpu_speed)
			board_cfg_pkg::speed_7_16:   cpu_en = tap_en[TAP_7_16];
			board_cfg_pkg::speed_14_318: cpu_en = tap_en[TAP_14_318];
			default:                     cpu_en = tap_en[TAP_4_77];
		endcase
	end

endmodule

//--- rtl/reset_sequencer.sv
module reset_sequencer #(
	parameter int RESET_HOLD      = 65535,
	parameter int CPU_RESET_DELAY = 42
) (
	input  logic                      clk_chipset,
	input  logic                      reset_wire,
	input  logic                      reset_button,
	input  board_timing_pkg::status_t status,
	input  logic                      splash_active,
	input  logic                      download_active,
	input  logic [7:0]                download_index,
	output logic                      sys_reset,
	output logic                      cpu_reset,
	output logic                      tandy_mode
);

	localparam int CW = board_timing_pkg::RESET_CNT_W;

	logic          reset_req;
	logic          reset_req_q;
	logic [CW-1:0] hold_cnt;
	logic [CW-1:0] cpu_cnt;

	// synchronous reset sources
	// bios download on index 0 restarts the machine
	assign reset_req = reset_button | status[board_cfg_pkg::STATUS_RESET_BIT] | splash_active |
		(download_active && (download_index == 8'd0));

	////////////////////////////////////////////////////////////////////////////
	// system reset stretch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			reset_req_q <= 1'b1;
			sys_reset   <= 1'b1;
			hold_cnt    <= '0;
		end else begin
			// one register on the merged request
			reset_req_q <= reset_req;
			if (reset_req_q) begin
				sys_reset <= 1'b1;
				hold_cnt  <= '0;
			end else if (sys_reset) begin
				if (hold_cnt == CW'(RESET_HOLD - 1)) begin
					sys_reset <= 1'b0;
				end else begin
					hold_cnt <= hold_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// cpu release and model latch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset  <= 1'b1;
			cpu_cnt    <= '0;
			tandy_mode <= 1'b0;
		end else if (sys_reset) begin
			cpu_reset  <= 1'b1;
			cpu_cnt    <= '0;
			// model only changes under system reset
			tandy_mode <= status[board_cfg_pkg::MODEL_BIT];
		end else if (cpu_reset) begin
			if (cpu_cnt == CW'(CPU_RESET_DELAY)) begin
				cpu_reset <= 1'b0;
			end else begin
				cpu_cnt <= cpu_cnt + 1'b1;
			end
		end
	end

endmodule

//--- rtl/settings_decoder.sv
module settings_decoder (
	input  logic                       clk_chipset,
	input  logic                       reset_wire,
	input  board_timing_pkg::status_t  status,
	input  logic                       biu_done,
	input  logic                       port_b_bit3,
	input  board_timing_pkg::joy_t     joy0_in,
	input  board_timing_pkg::joy_t     joy1_in,
	output board_cfg_pkg::cpu_speed_t  cpu_speed,
	output logic                       turbo_mode,
	output logic [3:0]                 port_c_nibble,
	output logic                       mda_mode,
	output logic                       ems_enabled,
	output logic [1:0]                 ems_frame,
	output logic [4:0]                 joy_opts,
	output board_timing_pkg::joy_t     joy0_out,
	output board_timing_pkg::joy_t     joy1_out
);

	logic [1:0] speed_code;
	logic [7:0] dip_sw;
	logic       joy_swap;

	assign speed_code = status[board_cfg_pkg::SPEED_LSB +: 2];

	// code 3 is not offered in the menu
	always_comb begin
		case (speed_code)
			2'd1:    cpu_speed = board_cfg_pkg::speed_7_16;
			2'd2:    cpu_speed = board_cfg_pkg::speed_14_318;
			default: cpu_speed = board_cfg_pkg::speed_4_77;
		endcase
	end

	// turbo only moves between bus cycles
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			turbo_mode <= 1'b0;
		end else if (biu_done) begin
			turbo_mode <= (speed_code == 2'd1) || (speed_code == 2'd2);
		end
	end

	// ppi port c reads half the dip bank
	assign mda_mode      = status[board_cfg_pkg::MDA_BIT];
	assign dip_sw        = mda_mode ? board_cfg_pkg::DIP_MDA : board_cfg_pkg::DIP_CGA;
	assign port_c_nibble = port_b_bit3 ? dip_sw[7:4] : dip_sw[3:0];

	// ems board
	assign ems_enabled = ~status[board_cfg_pkg::EMS_DISABLE_BIT];
	assign ems_frame   = status[board_cfg_pkg::EMS_FRAME_LSB +: 2];

	// joystick routing
	assign joy_opts = status[board_cfg_pkg::JOY_OPTS_LSB +: 5];
	assign joy_swap = status[board_cfg_pkg::JOY_SWAP_BIT];
	assign joy0_out = joy_swap ? joy1_in : joy0_in;
	assign joy1_out = joy_swap ? joy0_in : joy1_in;

endmodule

//--- rtl/sigma_delta_dac.sv
module sigma_delta_dac (
	input  logic                          clk_chipset,
	input  logic                          sys_reset,
	input  board_timing_pkg::dac_sample_t left_sample,
	input  board_timing_pkg::dac_sample_t right_sample,
	output logic                          audio_l,
	output logic                          audio_r
);

	localparam int SW = $bits(board_timing_pkg::dac_sample_t);

	board_timing_pkg::dac_sample_t acc_l;
	board_timing_pkg::dac_sample_t acc_r;
	logic [SW:0]                   sum_l;
	logic [SW:0]                   sum_r;

	// carry out sets the pulse density
	assign sum_l = {1'b0, acc_l} + {1'b0, left_sample};
	assign sum_r = {1'b0, acc_r} + {1'b0, right_sample};

	always_ff @(posedge clk_chipset or posedge sys_reset) begin
		if (sys_reset) begin
			acc_l   <= '0;
			acc_r   <= '0;
			audio_l <= 1'b0;
			audio_r <= 1'b0;
		end else begin
			acc_l   <= sum_l[SW-1:0];
			acc_r   <= sum_r[SW-1:0];
			audio_l <= sum_l[SW];
			audio_r <= sum_r[SW];
		end
	end

endmodule

//--- rtl/splash_timer.sv
module splash_timer #(
	parameter int TICKS_PER_SECOND = 14318000,
	parameter int SPLASH_SECONDS   = 5
) (
	input  logic clk_chipset,
	input  logic reset_wire,
	input  logic pixel_en,
	input  logic skip,
	output logic splash_active
);

	localparam int TICK_W = $clog2(TICKS_PER_SECOND + 1);
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0]  sec_cnt;
	logic              second_done;

	// last pixel enable of a second
	assign second_done = pixel_en && (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1));

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (skip) begin
				splash_active <= 1'b0;
			end else if (second_done) begin
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
				// final second ends the splash
				if (sec_cnt == SEC_W'(SPLASH_SECONDS - 1)) begin
					splash_active <= 1'b0;
				end
			end else if (pixel_en) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the board glue testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_board_top -Mdir obj_dir -f flist.f \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_board_top > sim.log 2>&1
# the log decides, not the exit code of the run
grep -q "^Test OK$" sim.log && echo "simulation passed" && exit 0 || {
	echo "simulation failed, see sim.log"
	exit 1
}

//--- sim/tb_board_top.sv
module tb_board_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SYNC_STAGES      = 3;
	localparam int RESET_HOLD       = 64;
	localparam int CPU_RESET_DELAY  = 42;
	localparam int TICKS_PER_SECOND = 20;
	localparam int SPLASH_SECONDS   = 5;
	localparam int NUM_ROWS         = 16;
	localparam int NUM_DAC          = 2;
	localparam int DAC_WINDOW       = 4096;
	localparam int SEL_SYS          = 0;
	localparam int SEL_CPU          = 1;
	localparam int SEL_SPLASH       = 2;

	// cycle budget with one term per test
	localparam int RESET_CYCLES  = 2 * (12 + RESET_HOLD + CPU_RESET_DELAY + 16);
	localparam int SPLASH_CYCLES = 8 + 2 * SPLASH_SECONDS * TICKS_PER_SECOND + 16;
	localparam int ENABLE_CYCLES = 4 * 6 * (2 * SYNC_STAGES + 6);
	localparam int TABLE_CYCLES  = NUM_ROWS * 2 + RESET_HOLD + 8;
	localparam int DAC_CYCLES    = NUM_DAC * (DAC_WINDOW + 2);
	localparam int MAX_CYCLES    = RESET_CYCLES + SPLASH_CYCLES + ENABLE_CYCLES +
		TABLE_CYCLES + DAC_CYCLES + 500;

	logic        clk_chipset;
	logic        reset_wire;
	logic [31:0] status;
	logic        reset_button;
	logic        download_active;
	logic [7:0]  download_index;
	logic        port_b_bit3;
	logic        biu_done;
	logic [31:0] joy0_in;
	logic [31:0] joy1_in;
	// 4.77, 7.16, 14.318, periph, opl2, uart
	logic [5:0]  taps;
	logic        speaker;
	logic [15:0] fm_sample;
	logic [7:0]  tandy_sample;

	logic        sys_reset;
	logic        cpu_reset;
	logic        tandy_mode;
	logic        splash_active;
	logic        pixel_en;
	logic        cpu_en;
	logic        periph_en;
	logic        opl2_en;
	logic        uart_en;
	board_cfg_pkg::cpu_speed_t cpu_speed;
	logic        turbo_mode;
	logic [3:0]  port_c_nibble;
	logic        mda_mode;
	logic        ems_enabled;
	logic [1:0]  ems_frame;
	logic [4:0]  joy_opts;
	logic [31:0] joy0_out;
	logic [31:0] joy1_out;
	logic [15:0] dac_sample;
	logic        audio_l;
	logic        audio_r;

	int          value_errors;
	int          event_errors;
	int          cycle_count;
	logic [31:0] lfsr_state;
	logic        turbo_model;

	////////////////////////////////////////////////////////////////////////////
	// stimulus table and expected decodes
	////////////////////////////////////////////////////////////////////////////

	logic [31:0] status_tab [NUM_ROWS];
	logic        portb_tab  [NUM_ROWS];
	logic [31:0] joy0_tab   [NUM_ROWS];
	logic [31:0] joy1_tab   [NUM_ROWS];
	logic        spk_tab    [NUM_ROWS];
	logic [15:0] fm_tab     [NUM_ROWS];
	logic [7:0]  tandy_tab  [NUM_ROWS];
	logic [3:0]  nibble_exp [NUM_ROWS];
	// speed, joy opts, ems frame, ems enable, mda
	logic [10:0] field_exp  [NUM_ROWS];
	logic [31:0] joy0_exp   [NUM_ROWS];
	logic [31:0] joy1_exp   [NUM_ROWS];
	logic [15:0] mix_exp    [NUM_ROWS];
	logic        turbo_exp  [NUM_ROWS];

	board_top #(
		.SYNC_STAGES      (SYNC_STAGES),
		.RESET_HOLD       (RESET_HOLD),
		.CPU_RESET_DELAY  (CPU_RESET_DELAY),
		.TICKS_PER_SECOND (TICKS_PER_SECOND),
		.SPLASH_SECONDS   (SPLASH_SECONDS)
	) dut (
		.clk_chipset     (clk_chipset),
		.reset_wire      (reset_wire),
		.status          (status),
		.reset_button    (reset_button),
		.download_active (download_active),
		.download_index  (download_index),
		.port_b_bit3     (port_b_bit3),
		.biu_done        (biu_done),
		.joy0_in         (joy0_in),
		.joy1_in         (joy1_in),
		.tap_cpu_4_77    (taps[0]),
		.tap_cpu_7_16    (taps[1]),
		.tap_cpu_14_318  (taps[2]),
		.tap_periph      (taps[3]),
		.tap_opl2        (taps[4]),
		.tap_uart        (taps[5]),
		.speaker         (speaker),
		.fm_sample       (fm_sample),
		.tandy_sample    (tandy_sample),
		.sys_reset       (sys_reset),
		.cpu_reset       (cpu_reset),
		.tandy_mode      (tandy_mode),
		.splash_active   (splash_active),
		.pixel_en        (pixel_en),
		.cpu_en          (cpu_en),
		.periph_en       (periph_en),
		.opl2_en         (opl2_en),
		.uart_en         (uart_en),
		.cpu_speed       (cpu_speed),
		.turbo_mode      (turbo_mode),
		.port_c_nibble   (port_c_nibble),
		.mda_mode        (mda_mode),
		.ems_enabled     (ems_enabled),
		.ems_frame       (ems_frame),
		.joy_opts        (joy_opts),
		.joy0_out        (joy0_out),
		.joy1_out        (joy1_out),
		.dac_sample      (dac_sample),
		.audio_l         (audio_l),
		.audio_r         (audio_r)
	);

	// 25 MHz chipset clock
	initial begin
		clk_chipset = 1'b0;
		forever #20 clk_chipset = ~clk_chipset;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// fibonacci lfsr x^32 + x^22 + x^2 + x + 1 shifted once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// half of 2*fm + speaker*2^14 + tandy*2^8 kept to 16 bits
	function automatic logic [15:0] mix_of(input logic spk, input logic [15:0] fm,
		input logic [7:0] td);
		int sum;
		sum = 2 * int'(fm) + 16384 * int'(spk) + 256 * int'(td);
		return 16'(sum / 2);
	endfunction

	// code 3 reads as 4.77
	// value doubles as the selected tap index
	function automatic logic [1:0] speed_of(input logic [1:0] code);
		return (code == 2'd3) ? 2'd0 : code;
	endfunction

	function automatic logic level_of(input int sel);
		case (sel)
			SEL_SYS: return sys_reset;
			SEL_CPU: return cpu_reset;
			default: return splash_active;
		endcase
	endfunction

	// inputs change just after the rising edge
	task automatic step();
		@(posedge clk_chipset);
		#2;
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errors++;
		$display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
	endtask

	task automatic event_error(input string what);
		event_errors++;
		$display("** Error: %s at %0t", what, $time);
	endtask

	// bounded count of cycles until the chosen reset output goes low
	task automatic cycles_to_fall(input int sel, input int limit, output int n);
		n = 0;
		while (level_of(sel) && n < limit) begin
			step();
			n++;
		end
	endtask

	task automatic apply_reset();
		logic [10:0] rst_state;
		reset_wire = 1'b1;
		repeat (8) step();
		rst_state = {sys_reset, cpu_reset, splash_active, turbo_mode, pixel_en, cpu_en,
			periph_en, opl2_en, uart_en, audio_l, audio_r};
		if (rst_state !== 11'b111_0000_0000) begin
			value_error("reset state", 32'(rst_state), 32'h700);
		end
		reset_wire = 1'b0;
	endtask

	// raise one tap and expect a single enable after the sync depth
	task automatic pulse_tap(input int idx, input logic [1:0] code);
		logic [3:0] en_exp;
		logic [3:0] en_got;
		logic       cpu_exp;
		taps[idx] = 1'b1;
		for (int s = 1; s <= SYNC_STAGES + 3; s++) begin
			step();
			en_got  = {uart_en, opl2_en, periph_en, pixel_en};
			en_exp  = '0;
			cpu_exp = 1'b0;
			if (s == SYNC_STAGES + 1) begin
				if (idx >= 2) begin
					en_exp = 4'b0001 << (idx - 2);
				end
				cpu_exp = (idx == int'(speed_of(code)));
			end
			if (en_got !== en_exp) begin
				value_error("uart/opl2/periph/pixel_en", 32'(en_got), 32'(en_exp));
			end
			if (cpu_en !== cpu_exp) begin
				value_error("cpu_en", 32'(cpu_en), 32'(cpu_exp));
			end
		end
		// no enable on a falling tap
		taps[idx] = 1'b0;
		repeat (SYNC_STAGES + 3) begin
			step();
			if ({uart_en, opl2_en, periph_en, pixel_en, cpu_en} !== 5'b0) begin
				event_error("enable pulse on a falling tap");
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run limit
	////////////////////////////////////////////////////////////////////////////

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_chipset);
			cycle_count++;
		end
		$display("run stopped: tests still running after %0d cycles", MAX_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int          n;
		int          pix;
		int          ones_l;
		int          ones_r;
		logic [15:0] s;
		logic [7:0]  dip;
		value_errors    = 0;
		event_errors    = 0;
		lfsr_state      = 32'h14e4;
		turbo_model     = 1'b0;
		reset_wire      = 1'b1;
		// skip and model bits set
		status          = 32'h0000_0088;
		reset_button    = 1'b0;
		download_active = 1'b0;
		download_index  = 8'h00;
		port_b_bit3     = 1'b0;
		biu_done        = 1'b0;
		joy0_in         = '0;
		joy1_in         = '0;
		taps            = '0;
		speaker         = 1'b0;
		fm_sample       = '0;
		tandy_sample    = '0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			// bit 0 is a reset request
			status_tab[r] = rand_bits(32) & 32'hFFFF_FFFE;
			portb_tab[r]  = 1'(rand_bits(1));
			joy0_tab[r]   = rand_bits(32);
			joy1_tab[r]   = rand_bits(32);
			spk_tab[r]    = 1'(rand_bits(1));
			fm_tab[r]     = 16'(rand_bits(16));
			tandy_tab[r]  = 8'(rand_bits(8));
			dip           = status_tab[r][4] ? 8'h3D : 8'h2D;
			nibble_exp[r] = portb_tab[r] ? dip[7:4] : dip[3:0];
			field_exp[r]  = {speed_of(status_tab[r][18:17]), status_tab[r][27:23],
				status_tab[r][13:12], ~status_tab[r][11], status_tab[r][4]};
			joy0_exp[r]   = status_tab[r][28] ? joy1_tab[r] : joy0_tab[r];
			joy1_exp[r]   = status_tab[r][28] ? joy0_tab[r] : joy1_tab[r];
			mix_exp[r]    = mix_of(spk_tab[r], fm_tab[r], tandy_tab[r]);
			turbo_exp[r]  = (status_tab[r][18:17] == 2'd1) || (status_tab[r][18:17] == 2'd2);
		end

		////////////////////////////////////////////////////////////////////////
		// reset sequence with the splash skipped
		////////////////////////////////////////////////////////////////////////

		apply_reset();
		cycles_to_fall(SEL_SPLASH, 8, n);
		if (n != 1) value_error("splash_active fall cycles", n, 1);
		cycles_to_fall(SEL_SYS, RESET_HOLD + 8, n);
		if (n != RESET_HOLD + 1) value_error("sys_reset fall cycles", n, RESET_HOLD + 1);
		if (tandy_mode !== 1'b1) value_error("tandy_mode", 32'(tandy_mode), 1);
		// model bit moves outside reset
		status[3] = 1'b0;
		cycles_to_fall(SEL_CPU, CPU_RESET_DELAY + 8, n);
		if (n != CPU_RESET_DELAY + 1) begin
			value_error("cpu_reset fall cycles", n, CPU_RESET_DELAY + 1);
		end
		if (tandy_mode !== 1'b1) value_error("tandy_mode", 32'(tandy_mode), 1);

		// one cycle button press
		reset_button = 1'b1;
		step();
		reset_button = 1'b0;
		step();
		if (sys_reset !== 1'b1) event_error("sys_reset did not rise after reset_button");
		cycles_to_fall(SEL_SYS, RESET_HOLD + 8, n);
		if (n != RESET_HOLD) value_error("sys_reset fall cycles", n, RESET_HOLD);
		if (cpu_reset !== 1'b1) event_error("cpu_reset was not held during the button reset");
		if (tandy_mode !== 1'b0) value_error("tandy_mode", 32'(tandy_mode), 0);
		cycles_to_fall(SEL_CPU, CPU_RESET_DELAY + 8, n);
		if (n != CPU_RESET_DELAY + 1) begin
			value_error("cpu_reset fall cycles", n, CPU_RESET_DELAY + 1);
		end

		////////////////////////////////////////////////////////////////////////
		// splash timer with a pixel enable every other cycle
		////////////////////////////////////////////////////////////////////////

		status = '0;
		apply_reset();
		pix = 0;
		for (int i = 0; i < SPLASH_CYCLES; i++) begin
			taps[2] = ~taps[2];
			step();
			if (!splash_active) break;
			if (pixel_en) pix++;
			if (!sys_reset) event_error("sys_reset low while splash_active was high");
		end
		if (splash_active) event_error("splash_active never fell");
		if (pix != SPLASH_SECONDS * TICKS_PER_SECOND) begin
			value_error("pixel enables during splash", pix, SPLASH_SECONDS * TICKS_PER_SECOND);
		end
		taps[2] = 1'b0;
		repeat (SYNC_STAGES + 3) step();

		// every tap under every speed code
		for (int c = 0; c < 4; c++) begin
			status = 32'(c) << 17;
			for (int t = 0; t < 6; t++) begin
				pulse_tap(t, 2'(c));
			end
		end

		////////////////////////////////////////////////////////////////////////
		// table rows for decodes, turbo and mix
		////////////////////////////////////////////////////////////////////////

		// mixer sits in sys_reset until the hold ends
		cycles_to_fall(SEL_SYS, RESET_HOLD + 8, n);
		if (sys_reset) event_error("sys_reset stuck high before the table");
		for (int r = 0; r < NUM_ROWS; r++) begin
			status       = status_tab[r];
			port_b_bit3  = portb_tab[r];
			joy0_in      = joy0_tab[r];
			joy1_in      = joy1_tab[r];
			speaker      = spk_tab[r];
			fm_sample    = fm_tab[r];
			tandy_sample = tandy_tab[r];
			step();
			if (port_c_nibble !== nibble_exp[r]) begin
				value_error("port_c_nibble", 32'(port_c_nibble), 32'(nibble_exp[r]));
			end
			if (mda_mode !== field_exp[r][0]) begin
				value_error("mda_mode", 32'(mda_mode), 32'(field_exp[r][0]));
			end
			if (ems_enabled !== field_exp[r][1]) begin
				value_error("ems_enabled", 32'(ems_enabled), 32'(field_exp[r][1]));
			end
			if (ems_frame !== field_exp[r][3:2]) begin
				value_error("ems_frame", 32'(ems_frame), 32'(field_exp[r][3:2]));
			end
			if (joy_opts !== field_exp[r][8:4]) begin
				value_error("joy_opts", 32'(joy_opts), 32'(field_exp[r][8:4]));
			end
			if (2'(cpu_speed) !== field_exp[r][10:9]) begin
				value_error("cpu_speed", 32'(cpu_speed), 32'(field_exp[r][10:9]));
			end
			if (joy0_out !== joy0_exp[r]) value_error("joy0_out", joy0_out, joy0_exp[r]);
			if (joy1_out !== joy1_exp[r]) value_error("joy1_out", joy1_out, joy1_exp[r]);
			if (dac_sample !== mix_exp[r]) begin
				value_error("dac_sample", 32'(dac_sample), 32'(mix_exp[r]));
			end
			// turbo holds without biu_done
			if (turbo_mode !== turbo_model) begin
				value_error("turbo_mode", 32'(turbo_mode), 32'(turbo_model));
			end
			biu_done = 1'b1;
			step();
			biu_done    = 1'b0;
			turbo_model = turbo_exp[r];
			if (turbo_mode !== turbo_model) begin
				value_error("turbo_mode", 32'(turbo_mode), 32'(turbo_model));
			end
		end

		// ones density on both dac outputs for a held sample
		for (int d = 0; d < NUM_DAC; d++) begin
			speaker      = 1'(rand_bits(1));
			fm_sample    = 16'(rand_bits(16));
			tandy_sample = 8'(rand_bits(8));
			s = mix_of(speaker, fm_sample, tandy_sample);
			step();
			if (dac_sample !== s) value_error("dac_sample", 32'(dac_sample), 32'(s));
			step();
			ones_l = 0;
			ones_r = 0;
			repeat (DAC_WINDOW) begin
				step();
				if (audio_l) ones_l++;
				if (audio_r) ones_r++;
			end
			if (ones_l * 16 - int'(s) > 16 || int'(s) - ones_l * 16 > 16) begin
				value_error("audio_l ones count", ones_l, 32'(s >> 4));
			end
			if (ones_r * 16 - int'(s) > 16 || int'(s) - ones_r * 16 > 16) begin
				value_error("audio_r ones count", ones_r, 32'(s >> 4));
			end
		end

		$display("checks done: %0d value errors, %0d other errors", value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
